//--- all.f
+incdir+.
wb_pkg.sv
rackctl_pkg.sv
link_req_if.sv
wb_link_mux.sv
link_req_fifo.sv
rackctl_link.sv
rack_bridge_top.sv
surf_link_model.sv
rack_bridge_tb.sv

//--- link_req_fifo.sv
`timescale 1ns/10ps
`include "rack_bridge_defines.svh"

module link_req_fifo (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,
    link_req_if.buffer  in,
    link_req_if.head    out
);
    import rackctl_pkg::*;

    localparam int AW = $clog2(`RB_FIFO_DEPTH);

    link_req_t      mem [`RB_FIFO_DEPTH];
    link_req_t      head;
    logic [AW-1:0]  wr_ptr_q;
    logic [AW-1:0]  rd_ptr_q;
    logic [AW:0]    cnt_q;
    logic           push;
    logic           pop;

    assign in.full = (cnt_q == (AW+1)'(`RB_FIFO_DEPTH));
    assign push    = in.stb && !in.full;
    assign pop     = out.pop && out.stb;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(`RB_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(`RB_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= '{we: in.we, adr: in.adr, sel: in.sel, dat: in.dat};
        end
    end

    // head is shown as soon as the count says it is there.
    assign head    = mem[rd_ptr_q];
    assign out.stb = (cnt_q != '0);
    assign out.we  = head.we;
    assign out.adr = head.adr;
    assign out.sel = head.sel;
    assign out.dat = head.dat;

    a_no_push_full: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        in.stb |-> !in.full);

    a_no_pop_empty: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        out.pop |-> out.stb);

endmodule

//--- link_req_if.sv
`timescale 1ns/10ps

interface link_req_if;
    import wb_pkg::*;

    logic       stb;
    logic       we;
    link_adr_t  adr;
    wb_dat_t    dat;
    wb_sel_t    sel;
    logic       full;
    logic       pop;

    // bus side pushes one request per stb and honours full.
    modport producer (
        output stb, we, adr, dat, sel,
        input  full
    );

    // write side of the queue.
    modport buffer (
        input  stb, we, adr, dat, sel,
        output full
    );

    // read side of the queue, stb means head valid here.
    modport head (
        output stb, we, adr, dat, sel,
        input  pop
    );

    modport consumer (
        input  stb, we, adr, dat, sel,
        output pop
    );

endinterface

//--- rack_bridge_defines.svh
`ifndef RACK_BRIDGE_DEFINES_SVH
`define RACK_BRIDGE_DEFINES_SVH

// number of serial control links, picked by select values 1 to 7.
`define RB_N_LINKS 7

// request words held per link before the bus cycle is stalled.
`define RB_FIFO_DEPTH 4

// cycles to wait for a response start bit after the last request bit.
`define RB_LINK_TIMEOUT 256

`endif

//--- rack_bridge_tb.sv
`timescale 1ns/10ps
`include "rack_bridge_defines.svh"

module rack_bridge_tb;
    import wb_pkg::*;
    import rackctl_pkg::*;

    // about 40 bus cycles of at most 150 clocks plus one link timeout, with wide margin.
    localparam int CYCLE_LIMIT = 20000;

    logic                    wb_clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    wb_adr_t                 wb_adr;
    wb_dat_t                 wb_dat_w;
    wb_sel_t                 wb_sel;
    wb_dat_t                 wb_dat_r;
    logic                    wb_ack;
    logic                    wb_err;
    link_sel_t               link_select;
    logic                    err_rst;
    link_err_t               bridge_err;
    logic [`RB_N_LINKS-1:0]  link_tx;
    logic [`RB_N_LINKS-1:0]  link_rx;
    logic [`RB_N_LINKS-1:0]  mute;

    wb_dat_t  exp_mem [`RB_N_LINKS][16];
    integer   seed;
    int       errors;
    int       checks;
    int       cycles;

    rack_bridge_top uut (
        .wb_clk_i      (wb_clk),
        .rst_n_i       (rst_n),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_sel_i      (wb_sel),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack),
        .wb_err_o      (wb_err),
        .link_select_i (link_select),
        .err_rst_i     (err_rst),
        .bridge_err_o  (bridge_err),
        .link_tx_o     (link_tx),
        .link_rx_i     (link_rx)
    );

    for (genvar k = 0; k < `RB_N_LINKS; k++) begin : g_board
        surf_link_model u_board (
            .clk_i  (wb_clk),
            .mute_i (mute[k]),
            .tx_i   (link_tx[k]),
            .rx_o   (link_rx[k])
        );
    end

    always #2 wb_clk = ~wb_clk;

    always @(posedge wb_clk) begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a bus cycle never ended", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    // byte lanes with sel set take the new data.
    function automatic wb_dat_t merge_bytes(wb_dat_t old, wb_dat_t nw, wb_sel_t s);
        wb_dat_t r;
        r = old;
        for (int l = 0; l < 4; l++) begin
            if (s[l]) begin
                r[8*l +: 8] = nw[8*l +: 8];
            end
        end
        return r;
    endfunction

    task automatic bus_cycle(input link_sel_t lsel, input logic w, input wb_adr_t a,
                             input wb_dat_t d, input wb_sel_t s,
                             output logic ack, output logic err, output wb_dat_t rd);
        @(negedge wb_clk);
        link_select = lsel;
        wb_we       = w;
        wb_adr      = a;
        wb_dat_w    = d;
        wb_sel      = s;
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        // stalls here while the link queue is full or the remote is slow.
        do begin
            @(negedge wb_clk);
        end while (!wb_ack && !wb_err);
        ack    = wb_ack;
        err    = wb_err;
        rd     = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic bus_write(input link_sel_t lsel, input wb_adr_t a, input wb_dat_t d,
                             input wb_sel_t s);
        logic     ack;
        logic     err;
        wb_dat_t  rd;
        bus_cycle(lsel, 1'b1, a, d, s, ack, err, rd);
        check_value("wb_ack_o", 32'(ack), 32'd1);
        check_value("wb_err_o", 32'(err), 32'd0);
        exp_mem[lsel - 3'd1][a[3:0]] = merge_bytes(exp_mem[lsel - 3'd1][a[3:0]], d, s);
    endtask

    task automatic bus_read(input link_sel_t lsel, input wb_adr_t a);
        logic     ack;
        logic     err;
        wb_dat_t  rd;
        bus_cycle(lsel, 1'b0, a, '0, 4'hf, ack, err, rd);
        check_value("wb_ack_o", 32'(ack), 32'd1);
        check_value("wb_err_o", 32'(err), 32'd0);
        check_value("wb_dat_o", rd, exp_mem[lsel - 3'd1][a[3:0]]);
    endtask

    task automatic write_then_read();
        bus_write(3'd1, 25'h00_0005, 32'hcafe_0001, 4'hf);
        bus_read(3'd1, 25'h00_0005);
    endtask

    task automatic isolate_links();
        for (int k = 1; k <= `RB_N_LINKS; k++) begin
            bus_write(link_sel_t'(k), 25'h01_0003, $random(seed), 4'hf);
        end
        for (int k = 1; k <= `RB_N_LINKS; k++) begin
            bus_read(link_sel_t'(k), 25'h01_0003);
        end
    endtask

    // more posted writes than the queue holds.
    task automatic burst_writes();
        for (int i = 0; i < 6; i++) begin
            bus_write(3'd4, wb_adr_t'(i), $random(seed), 4'hf);
        end
        for (int i = 0; i < 6; i++) begin
            bus_read(3'd4, wb_adr_t'(i));
        end
    endtask

    task automatic partial_byte_write();
        bus_write(3'd2, 25'h00_0007, 32'h1122_3344, 4'hf);
        bus_write(3'd2, 25'h00_0007, 32'haabb_ccdd, 4'b0101);
        bus_read(3'd2, 25'h00_0007);
    endtask

    task automatic select_zero_error();
        logic     ack;
        logic     err;
        wb_dat_t  rd;
        bus_cycle(3'd0, 1'b1, 25'h00_0001, 32'h5555_aaaa, 4'hf, ack, err, rd);
        check_value("wb_ack_o", 32'(ack), 32'd0);
        check_value("wb_err_o", 32'(err), 32'd1);
        bus_cycle(3'd0, 1'b0, 25'h00_0001, '0, 4'hf, ack, err, rd);
        check_value("wb_ack_o", 32'(ack), 32'd0);
        check_value("wb_err_o", 32'(err), 32'd1);
    endtask

    task automatic muted_link_timeout();
        logic     ack;
        logic     err;
        wb_dat_t  rd;
        check_value("bridge_err_o", 32'(bridge_err), 32'h00);
        mute[5] = 1'b1;
        bus_cycle(3'd6, 1'b0, 25'h00_0002, '0, 4'hf, ack, err, rd);
        check_value("wb_ack_o", 32'(ack), 32'd0);
        check_value("wb_err_o", 32'(err), 32'd1);
        check_value("bridge_err_o", 32'(bridge_err), 32'h20);
        @(negedge wb_clk);
        err_rst = 1'b1;
        @(negedge wb_clk);
        err_rst = 1'b0;
        check_value("bridge_err_o", 32'(bridge_err), 32'h00);
        mute[5] = 1'b0;
        bus_read(3'd6, 25'h00_0002);
    endtask

    initial begin
        seed        = 32'ha2d0_6a7e;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        wb_clk      = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        link_select = '0;
        err_rst     = 1'b0;
        mute        = '0;
        // same fill as the remote board memories.
        for (int k = 0; k < `RB_N_LINKS; k++) begin
            for (int i = 0; i < 16; i++) begin
                exp_mem[k][i] = {8{4'(i)}};
            end
        end
        repeat (10) @(negedge wb_clk);
        check_value("wb_ack_o", 32'(wb_ack), 32'd0);
        check_value("wb_err_o", 32'(wb_err), 32'd0);
        check_value("link_tx_o", 32'(link_tx), 32'h7f);
        check_value("bridge_err_o", 32'(bridge_err), 32'h00);
        rst_n = 1'b1;
        write_then_read();
        isolate_links();
        burst_writes();
        partial_byte_write();
        select_zero_error();
        muted_link_timeout();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rack_bridge_top.sv
`timescale 1ns/10ps
`include "rack_bridge_defines.svh"

module rack_bridge_top (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_pkg::wb_adr_t         wb_adr_i,
    input  wb_pkg::wb_dat_t         wb_dat_i,
    input  wb_pkg::wb_sel_t         wb_sel_i,
    output wb_pkg::wb_dat_t         wb_dat_o,
    output logic                    wb_ack_o,
    output logic                    wb_err_o,
    input  wb_pkg::link_sel_t       link_select_i,
    input  logic                    err_rst_i,
    output rackctl_pkg::link_err_t  bridge_err_o,
    output logic [`RB_N_LINKS-1:0]  link_tx_o,
    input  logic [`RB_N_LINKS-1:0]  link_rx_i
);
    import wb_pkg::*;

    link_req_if req_if [`RB_N_LINKS] ();
    link_req_if head_if [`RB_N_LINKS] ();

    logic [`RB_N_LINKS-1:0]  rsp_stb;
    logic [`RB_N_LINKS-1:0]  rsp_err;
    wb_dat_t                 rsp_dat [`RB_N_LINKS];

    wb_link_mux u_mux (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .link_select_i (link_select_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .wb_err_o      (wb_err_o),
        .req           (req_if),
        .rsp_stb_i     (rsp_stb),
        .rsp_err_i     (rsp_err),
        .rsp_dat_i     (rsp_dat)
    );

    // select value k+1 lands on g_link[k].
    for (genvar k = 0; k < `RB_N_LINKS; k++) begin : g_link
        link_req_fifo u_fifo (
            .wb_clk_i (wb_clk_i),
            .rst_n_i  (rst_n_i),
            .in       (req_if[k]),
            .out      (head_if[k])
        );

        rackctl_link u_link (
            .wb_clk_i     (wb_clk_i),
            .rst_n_i      (rst_n_i),
            .req          (head_if[k]),
            .rsp_stb_o    (rsp_stb[k]),
            .rsp_err_o    (rsp_err[k]),
            .rsp_dat_o    (rsp_dat[k]),
            .err_rst_i    (err_rst_i),
            .bridge_err_o (bridge_err_o[k]),
            .link_tx_o    (link_tx_o[k]),
            .link_rx_i    (link_rx_i[k])
        );
    end

endmodule

//--- rackctl_link.sv
`timescale 1ns/10ps
`include "rack_bridge_defines.svh"

module rackctl_link (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    link_req_if.consumer     req,
    output logic             rsp_stb_o,
    output logic             rsp_err_o,
    output wb_pkg::wb_dat_t  rsp_dat_o,
    input  logic             err_rst_i,
    output logic             bridge_err_o,
    output logic             link_tx_o,
    input  logic             link_rx_i
);
    import wb_pkg::*;
    import rackctl_pkg::*;

    // payload bits after the start bit, reads carry no data.
    localparam int WR_BITS = $bits(link_req_t);
    localparam int RD_BITS = WR_BITS - $bits(wb_dat_t);
    localparam int TW      = $clog2(`RB_LINK_TIMEOUT);

    link_state_t           state_q;
    logic [WR_BITS-1:0]    sh_q;
    link_cnt_t             cnt_q;
    logic [TW-1:0]         tmr_q;
    logic                  rd_q;
    logic                  tx_q;
    logic [31:0]           rx_sh_q;
    logic [32:0]           rx_word;
    logic                  rsp_stb_q;
    logic                  rsp_err_q;
    wb_dat_t               rsp_dat_q;
    logic                  err_q;
    logic                  timeout;
    logic                  rx_done;
    logic                  status;
    logic                  set_err;

    // pop the head the cycle it is seen, start bit goes out next.
    assign req.pop = (state_q == IDLE) && req.stb;

    assign rx_word = {rx_sh_q, link_rx_i};
    // status leads the data on reads and stands alone on writes.
    assign status  = rd_q ? rx_word[32] : link_rx_i;
    assign rx_done = (state_q == RECV) && (cnt_q == link_cnt_t'(1));
    assign timeout = (state_q == WAIT_RSP) && link_rx_i &&
                     (tmr_q == TW'(`RB_LINK_TIMEOUT - 1));
    assign set_err = timeout || (rx_done && status);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            tmr_q     <= '0;
            rd_q      <= 1'b0;
            tx_q      <= 1'b1;
            rsp_stb_q <= 1'b0;
            rsp_err_q <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            rsp_stb_q <= 1'b0;
            if (set_err) begin
                err_q <= 1'b1;
            end else if (err_rst_i) begin
                err_q <= 1'b0;
            end
            case (state_q)
                IDLE: begin
                    if (req.stb) begin
                        tx_q    <= 1'b0;
                        rd_q    <= !req.we;
                        cnt_q   <= req.we ? link_cnt_t'(WR_BITS) : link_cnt_t'(RD_BITS);
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    tx_q  <= sh_q[WR_BITS-1];
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == link_cnt_t'(1)) begin
                        tmr_q   <= '0;
                        state_q <= WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    tx_q  <= 1'b1;
                    tmr_q <= tmr_q + 1'b1;
                    if (!link_rx_i) begin
                        cnt_q   <= rd_q ? link_cnt_t'(33) : link_cnt_t'(1);
                        state_q <= RECV;
                    end else if (timeout) begin
                        rsp_stb_q <= rd_q;
                        rsp_err_q <= 1'b1;
                        state_q   <= IDLE;
                    end
                end
                RECV: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (rx_done) begin
                        rsp_stb_q <= rd_q;
                        rsp_err_q <= status;
                        state_q   <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req.pop) begin
            sh_q <= {req.we, req.adr, req.sel, req.dat};
        end else if (state_q == SEND) begin
            sh_q <= {sh_q[WR_BITS-2:0], 1'b0};
        end
        if (state_q == RECV) begin
            rx_sh_q <= rx_word[31:0];
        end
        if (rx_done) begin
            rsp_dat_q <= rx_word[31:0];
        end
    end

    assign link_tx_o    = tx_q;
    assign rsp_stb_o    = rsp_stb_q;
    assign rsp_err_o    = rsp_err_q;
    assign rsp_dat_o    = rsp_dat_q;
    assign bridge_err_o = err_q;

    a_tx_idle_high: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> link_tx_o);

endmodule

//--- rackctl_pkg.sv
`include "rack_bridge_defines.svh"

package rackctl_pkg;

    // serializer states of one link.
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_RSP,
        RECV
    } link_state_t;

    // counts frame bits, long enough for a full write frame.
    typedef logic [5:0] link_cnt_t;

    typedef logic [`RB_N_LINKS-1:0] link_err_t;

    // one queued request, fields in wire order, MSB first.
    typedef struct packed {
        logic               we;
        wb_pkg::link_adr_t  adr;
        wb_pkg::wb_sel_t    sel;
        wb_pkg::wb_dat_t    dat;
    } link_req_t;

endpackage

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rack_bridge_tb \
    -f all.f -o rack_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rack_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- surf_link_model.sv
`timescale 1ns/10ps

module surf_link_model (
    input  logic  clk_i,
    input  logic  mute_i,
    input  logic  tx_i,
    output logic  rx_o
);
    logic [31:0]  mem [16];
    logic         we;
    // address bits then byte select, as they arrive on the wire.
    logic [25:0]  hdr;
    logic [31:0]  dat;
    logic [31:0]  rsp;

    initial begin
        rx_o = 1'b1;
        for (int i = 0; i < 16; i++) begin
            mem[i] = {8{4'(i)}};
        end
        forever begin
            @(negedge clk_i);
            // a low tx while idle is a start bit.
            if (!tx_i) begin
                @(negedge clk_i);
                we = tx_i;
                for (int b = 0; b < 26; b++) begin
                    @(negedge clk_i);
                    hdr = {hdr[24:0], tx_i};
                end
                if (we) begin
                    for (int b = 0; b < 32; b++) begin
                        @(negedge clk_i);
                        dat = {dat[30:0], tx_i};
                    end
                    for (int l = 0; l < 4; l++) begin
                        if (hdr[l]) begin
                            mem[hdr[7:4]][8*l +: 8] = dat[8*l +: 8];
                        end
                    end
                end
                rsp = mem[hdr[7:4]];
                repeat (3) @(negedge clk_i);
                if (!mute_i) begin
                    rx_o = 1'b0;
                    @(negedge clk_i);
                    // status bit, this board never reports an error.
                    rx_o = 1'b0;
                    if (!we) begin
                        for (int b = 31; b >= 0; b--) begin
                            @(negedge clk_i);
                            rx_o = rsp[b];
                        end
                    end
                    @(negedge clk_i);
                    rx_o = 1'b1;
                end
            end
        end
    end

endmodule

//--- wb_link_mux.sv
`timescale 1ns/10ps
`include "rack_bridge_defines.svh"

module wb_link_mux (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_pkg::wb_adr_t         wb_adr_i,
    input  wb_pkg::wb_dat_t         wb_dat_i,
    input  wb_pkg::wb_sel_t         wb_sel_i,
    input  wb_pkg::link_sel_t       link_select_i,
    output wb_pkg::wb_dat_t         wb_dat_o,
    output logic                    wb_ack_o,
    output logic                    wb_err_o,
    link_req_if.producer            req [`RB_N_LINKS],
    input  logic [`RB_N_LINKS-1:0]  rsp_stb_i,
    input  logic [`RB_N_LINKS-1:0]  rsp_err_i,
    input  wb_pkg::wb_dat_t         rsp_dat_i [`RB_N_LINKS]
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_RSP,
        M_END
    } mux_state_t;

    mux_state_t              state_q;
    link_sel_t               idx;
    link_sel_t               cur_q;
    logic [`RB_N_LINKS-1:0]  full_vec;
    logic [`RB_N_LINKS-1:0]  req_stb_q;
    logic                    req_we_q;
    link_adr_t               req_adr_q;
    wb_dat_t                 req_dat_q;
    wb_sel_t                 req_sel_q;
    logic                    ack_q;
    logic                    err_q;
    wb_dat_t                 dat_q;

    // select k+1 is link k.
    assign idx = link_select_i - 3'd1;

    for (genvar k = 0; k < `RB_N_LINKS; k++) begin : g_req
        assign req[k].stb  = req_stb_q[k];
        assign req[k].we   = req_we_q;
        assign req[k].adr  = req_adr_q;
        assign req[k].dat  = req_dat_q;
        assign req[k].sel  = req_sel_q;
        assign full_vec[k] = req[k].full;
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= M_IDLE;
            cur_q     <= '0;
            req_stb_q <= '0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            req_stb_q <= '0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        if (link_select_i == '0) begin
                            err_q   <= 1'b1;
                            state_q <= M_END;
                        end else if (!full_vec[idx]) begin
                            req_stb_q[idx] <= 1'b1;
                            cur_q          <= idx;
                            // writes are posted, reads wait for the remote.
                            if (wb_we_i) begin
                                ack_q   <= 1'b1;
                                state_q <= M_END;
                            end else begin
                                state_q <= M_RSP;
                            end
                        end
                    end
                end
                M_RSP: begin
                    if (rsp_stb_i[cur_q]) begin
                        ack_q   <= !rsp_err_i[cur_q];
                        err_q   <= rsp_err_i[cur_q];
                        state_q <= M_END;
                    end
                end
                // master drops stb while ack or err is up.
                M_END: state_q <= M_IDLE;
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == M_IDLE) begin
            req_we_q  <= wb_we_i;
            req_adr_q <= wb_adr_i[21:0];
            req_dat_q <= wb_dat_i;
            req_sel_q <= wb_sel_i;
        end
        if (state_q == M_RSP && rsp_stb_i[cur_q]) begin
            dat_q <= rsp_dat_i[cur_q];
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_err_o = err_q;
    assign wb_dat_o = dat_q;

    a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !(wb_ack_o && wb_err_o));

endmodule

//--- wb_pkg.sv
package wb_pkg;

    // full target address as seen on the bus.
    typedef logic [24:0] wb_adr_t;

    // address forwarded to the remote board, low bits of wb_adr_t.
    typedef logic [21:0] link_adr_t;

    typedef logic [31:0] wb_dat_t;

    typedef logic [3:0] wb_sel_t;

    // 0 is no link, 1 to 7 pick a link.
    typedef logic [2:0] link_sel_t;

endpackage
